//--- cache_system.f
design/cache_pkg.sv
design/bus_pkg.sv
design/cache_array.sv
design/cache_driver.sv
design/biu.sv
design/cache_system.sv
test/tb_memory.sv
test/cache_system_tb.sv

//--- design/biu.sv
module biu import cache_pkg::*, bus_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    input  line_req_t i_req,
    input  mem_rsp_t  i_mem,
    output logic      o_done,
    output line_t     o_line,
    output mem_req_t  o_mem
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        REQ  = 2'b01,
        DONE = 2'b10
    } state_t;

    state_t state_q;
    logic   we_q;
    addr_t  addr_q;
    line_t  data_q;
    line_t  line_q;

    // done lasts one cycle, after which a held en starts the next request.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (i_req.en) state_q <= REQ;
                REQ:     if (i_mem.ack) state_q <= DONE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_req.en) begin
            we_q   <= i_req.we;
            addr_q <= i_req.addr;
            data_q <= i_req.data;
        end
        if (state_q == REQ && i_mem.ack) begin
            line_q <= i_mem.data;  // read data, unused after a write-back.
        end
    end

    assign o_done = (state_q == DONE);
    assign o_line = line_q;

    assign o_mem.req  = (state_q == REQ);
    assign o_mem.we   = we_q;
    assign o_mem.addr = addr_q;
    assign o_mem.data = data_q;

    // the driver keeps en high for the whole memory transaction.
    a_req_latched: assert property (
        @(posedge clk) disable iff (!n_rst) o_mem.req |-> i_req.en
    );

endmodule

//--- design/bus_pkg.sv
package bus_pkg;

    // line request from the cache driver to the bus unit.
    typedef struct packed {
        logic             en;
        logic             we;
        cache_pkg::addr_t addr;  // always line aligned.
        cache_pkg::line_t data;
    } line_req_t;

    // memory transaction issued by the bus unit.
    typedef struct packed {
        logic             req;
        logic             we;
        cache_pkg::addr_t addr;
        cache_pkg::line_t data;
    } mem_req_t;

    // memory answer, ack pulses for one cycle with the read line.
    typedef struct packed {
        logic             ack;
        cache_pkg::line_t data;
    } mem_rsp_t;

endpackage

//--- design/cache_array.sv
module cache_array import cache_pkg::*; #(
    parameter int  CACHE_SIZE  = 256,
    localparam int INDEX_COUNT = CACHE_SIZE / LINE_BYTES,
    localparam int INDEX_WIDTH = $clog2(INDEX_COUNT),
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    i_re,
    input  logic                    i_we,
    input  logic                    i_fe,
    input  logic [OFFSET_WIDTH-1:0] i_offset,
    input  logic [INDEX_WIDTH-1:0]  i_index,
    input  logic [TAG_WIDTH-1:0]    i_tag,
    input  line_t                   i_fdata,
    input  word_t                   i_wdata,
    output logic                    o_valid,
    output logic                    o_dirty,
    output logic                    o_hit,
    output logic [TAG_WIDTH-1:0]    o_tag,
    output line_t                   o_vdata,
    output word_t                   o_rdata
);

    localparam int BYTE_BITS = $clog2(DATA_WIDTH / 8);
    localparam int SEL_WIDTH = OFFSET_WIDTH - BYTE_BITS;

    logic [TAG_WIDTH-1:0]   tag_mem [INDEX_COUNT];
    line_t                  data_mem [INDEX_COUNT];
    logic [INDEX_COUNT-1:0] valid_q;
    logic [INDEX_COUNT-1:0] dirty_q;

    logic [SEL_WIDTH-1:0]   word_sel;
    logic                   tag_match;
    logic                   word_we;

    assign word_sel  = i_offset[OFFSET_WIDTH-1:BYTE_BITS];  // byte bits inside a word are ignored.
    assign tag_match = valid_q[i_index] && (tag_mem[i_index] == i_tag);
    assign word_we   = i_we && tag_match;

    assign o_hit   = (i_re || i_we) && tag_match;
    assign o_valid = valid_q[i_index];
    assign o_dirty = dirty_q[i_index];
    assign o_tag   = tag_mem[i_index];
    assign o_vdata = data_mem[i_index];  // the line that a fill at this index would replace.
    assign o_rdata = data_mem[i_index][word_sel*DATA_WIDTH +: DATA_WIDTH];

    // a fill brings a clean copy, a word write makes it dirty.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fe) begin
            valid_q[i_index] <= 1'b1;
            dirty_q[i_index] <= 1'b0;
        end else if (word_we) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fe) begin
            tag_mem[i_index]  <= i_tag;
            data_mem[i_index] <= i_fdata;
        end else if (word_we) begin
            data_mem[i_index][word_sel*DATA_WIDTH +: DATA_WIDTH] <= i_wdata;
        end
    end

    // the driver only fills in its miss state and only writes while idle.
    a_fill_not_write: assert property (
        @(posedge clk) disable iff (!n_rst) !(i_fe && i_we)
    );

endmodule

//--- design/cache_driver.sv
module cache_driver import cache_pkg::*, bus_pkg::*; #(
    parameter int CACHE_SIZE = 256
) (
    input  logic      clk,
    input  logic      n_rst,
    input  logic      i_re,
    input  logic      i_we,
    input  addr_t     i_addr,
    input  word_t     i_data,
    input  logic      i_biu_done,
    input  line_t     i_biu_line,
    output word_t     o_data,
    output logic      o_hit,
    output logic      o_busy,
    output line_req_t o_biu_req
);

    localparam int INDEX_WIDTH = $clog2(CACHE_SIZE / LINE_BYTES);
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        MISS   = 2'b01,
        VICTIM = 2'b10
    } state_t;

    state_t                  state_q;
    state_t                  state_d;

    logic [OFFSET_WIDTH-1:0] req_offset;
    logic [INDEX_WIDTH-1:0]  req_index;
    logic [TAG_WIDTH-1:0]    req_tag;

    logic                    arr_we;
    logic                    arr_fe;
    logic                    arr_hit;
    logic                    arr_valid;
    logic                    arr_dirty;
    logic [TAG_WIDTH-1:0]    arr_tag;
    line_t                   arr_vdata;

    logic                    evict;
    line_t                   vdata_q;
    addr_t                   vaddr_q;

    assign req_offset = i_addr[OFFSET_WIDTH-1:0];
    assign req_index  = i_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag    = i_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign arr_we = i_we && (state_q == IDLE);
    assign arr_fe = i_biu_done && (state_q == MISS);  // the fill lands on the done edge.
    assign evict  = arr_valid && arr_dirty;

    assign o_hit  = arr_hit;
    assign o_busy = (state_q != IDLE);

    assign o_biu_req.en   = (state_q != IDLE);
    assign o_biu_req.we   = (state_q == VICTIM);
    assign o_biu_req.addr = (state_q == VICTIM) ? vaddr_q : {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign o_biu_req.data = vdata_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if ((i_re || i_we) && !arr_hit) state_d = MISS;
            MISS:    if (i_biu_done) state_d = evict ? VICTIM : IDLE;
            VICTIM:  if (i_biu_done) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // old line and its address, taken before the fill overwrites them.
    always_ff @(posedge clk) begin
        if (arr_fe) begin
            vdata_q <= arr_vdata;
            vaddr_q <= {arr_tag, req_index, {OFFSET_WIDTH{1'b0}}};
        end
    end

    cache_array #(
        .CACHE_SIZE(CACHE_SIZE)
    ) i_cache_array (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_re     (i_re),
        .i_we     (arr_we),
        .i_fe     (arr_fe),
        .i_offset (req_offset),
        .i_index  (req_index),
        .i_tag    (req_tag),
        .i_fdata  (i_biu_line),
        .i_wdata  (i_data),
        .o_valid  (arr_valid),
        .o_dirty  (arr_dirty),
        .o_hit    (arr_hit),
        .o_tag    (arr_tag),
        .o_vdata  (arr_vdata),
        .o_rdata  (o_data)
    );

    a_done_with_en: assert property (
        @(posedge clk) disable iff (!n_rst) i_biu_done |-> o_biu_req.en
    );

endmodule

//--- design/cache_pkg.sv
package cache_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int LINE_BYTES   = 16;
    localparam int LINE_WIDTH   = LINE_BYTES * 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);

    // one host data word.
    typedef logic [DATA_WIDTH-1:0] word_t;

    // byte address as seen by the host and the memory.
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // one full cache line, word 0 in the lowest bits.
    typedef logic [LINE_WIDTH-1:0] line_t;

endpackage

//--- design/cache_system.sv
module cache_system import cache_pkg::*, bus_pkg::*; #(
    parameter int CACHE_SIZE = 256
) (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     i_re,
    input  logic     i_we,
    input  addr_t    i_addr,
    input  word_t    i_data,
    input  mem_rsp_t i_mem,
    output word_t    o_data,
    output logic     o_hit,
    output logic     o_busy,
    output mem_req_t o_mem
);

    line_req_t biu_req;
    logic      biu_done;
    line_t     biu_line;

    cache_driver #(
        .CACHE_SIZE(CACHE_SIZE)
    ) i_cache_driver (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_re       (i_re),
        .i_we       (i_we),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .i_biu_done (biu_done),
        .i_biu_line (biu_line),
        .o_data     (o_data),
        .o_hit      (o_hit),
        .o_busy     (o_busy),
        .o_biu_req  (biu_req)
    );

    biu i_biu (
        .clk    (clk),
        .n_rst  (n_rst),
        .i_req  (biu_req),
        .i_mem  (i_mem),
        .o_done (biu_done),
        .o_line (biu_line),
        .o_mem  (o_mem)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_system_tb \
    -f cache_system.f -o sim_cache_system
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cache_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
exit 0

//--- test/cache_system_tb.sv
module cache_system_tb import cache_pkg::*, bus_pkg::*; ();

    localparam int CACHE_SIZE  = 256;
    localparam int INDEX_COUNT = CACHE_SIZE / LINE_BYTES;
    localparam int INDEX_WIDTH = $clog2(INDEX_COUNT);
    localparam int WORDS       = LINE_BYTES / 4;
    localparam int MAX_WAIT    = 6;
    localparam int MEM_LATENCY = MAX_WAIT + 2;  // worst cycles from mem req to ack.
    localparam int RANDOM_ROWS = 60;
    localparam int ROWS        = 9 + RANDOM_ROWS;
    localparam int TIMEOUT     = ROWS * (MEM_LATENCY + 4) * 2 + 100;

    typedef struct packed {
        int    test;
        logic  we;
        addr_t addr;
        word_t data;     // write data, or the expected read data.
        logic  exp_hit;  // hit in the first cycle of the request.
        logic  exp_wb;
        addr_t wb_addr;
        line_t wb_line;
    } row_t;

    logic     clk;
    logic     n_rst;
    logic     host_re;
    logic     host_we;
    addr_t    host_addr;
    word_t    host_data;
    word_t    rdata;
    logic     hit;
    logic     busy;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    int       log_count;
    addr_t    log_addr;
    line_t    log_line;

    row_t  stim_table [$];
    word_t ref_mem [addr_t];
    logic  sh_valid [INDEX_COUNT];
    logic  sh_dirty [INDEX_COUNT];
    addr_t sh_tag [INDEX_COUNT];
    int    n_evict;
    int    checks;
    int    errors;
    int    cycles;

    cache_system #(
        .CACHE_SIZE(CACHE_SIZE)
    ) i_cache_system (
        .clk    (clk),
        .n_rst  (n_rst),
        .i_re   (host_re),
        .i_we   (host_we),
        .i_addr (host_addr),
        .i_data (host_data),
        .i_mem  (mem_rsp),
        .o_data (rdata),
        .o_hit  (hit),
        .o_busy (busy),
        .o_mem  (mem_req)
    );

    tb_memory #(
        .MAX_WAIT(MAX_WAIT)
    ) i_tb_memory (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_req      (mem_req),
        .o_rsp      (mem_rsp),
        .o_wr_count (log_count),
        .o_wr_addr  (log_addr),
        .o_wr_line  (log_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

    function automatic word_t read_ref(input addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ 32'hA5A5_0000;
    endfunction

    // four tags over every index and every word of a line.
    function automatic addr_t random_addr();
        return (addr_t'($urandom_range(3, 0)) << (OFFSET_WIDTH + INDEX_WIDTH))
             | (addr_t'($urandom_range(INDEX_COUNT - 1, 0)) << OFFSET_WIDTH)
             | (addr_t'($urandom_range(WORDS - 1, 0)) << 2);
    endfunction

    task automatic add_row(input int test, input logic we, input addr_t addr, input word_t data);
        row_t r;
        r      = '0;
        r.test = test;
        r.we   = we;
        r.addr = addr;
        r.data = data;
        stim_table.push_back(r);
    endtask

    // walks the table once with a shadow of tags and dirty bits to fill in the expected values.
    task automatic predict_table();
        row_t                   r;
        logic [INDEX_WIDTH-1:0] idx;
        addr_t                  tag;
        addr_t                  word_addr;
        for (int i = 0; i < INDEX_COUNT; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
            sh_tag[i]   = '0;
        end
        n_evict = 0;
        for (int i = 0; i < stim_table.size(); i++) begin
            r         = stim_table[i];
            idx       = r.addr[OFFSET_WIDTH +: INDEX_WIDTH];
            tag       = r.addr >> (OFFSET_WIDTH + INDEX_WIDTH);
            word_addr = {r.addr[ADDR_WIDTH-1:2], 2'b00};
            r.exp_hit = sh_valid[idx] && (sh_tag[idx] == tag);
            r.exp_wb  = !r.exp_hit && sh_valid[idx] && sh_dirty[idx];
            if (r.exp_wb) begin
                n_evict++;
                r.wb_addr = (sh_tag[idx] << (OFFSET_WIDTH + INDEX_WIDTH))
                          | (addr_t'(idx) << OFFSET_WIDTH);
                for (int w = 0; w < WORDS; w++) begin
                    r.wb_line[w*DATA_WIDTH +: DATA_WIDTH] = read_ref(r.wb_addr + addr_t'(4 * w));
                end
            end
            if (!r.exp_hit) begin
                sh_valid[idx] = 1'b1;
                sh_tag[idx]   = tag;
                sh_dirty[idx] = 1'b0;
            end
            if (r.we) begin
                ref_mem[word_addr] = r.data;
                sh_dirty[idx]      = 1'b1;
            end else begin
                r.data = read_ref(word_addr);
            end
            stim_table[i] = r;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // holds the request until it hits with the cache idle.
    task automatic run_row(input row_t r);
        int wb_before;
        wb_before = log_count;
        @(posedge clk);
        host_re   <= !r.we;
        host_we   <= r.we;
        host_addr <= r.addr;
        host_data <= r.we ? r.data : '0;
        @(negedge clk);
        check_flag("o_hit", hit, r.exp_hit);
        check_flag("o_busy", busy, 1'b0);
        while (!(hit && !busy)) begin
            @(negedge clk);
        end
        if (!r.we) begin
            check_word("o_data", rdata, r.data);
        end
        check_word("write-back count", word_t'(log_count - wb_before), word_t'(r.exp_wb));
        if (r.exp_wb) begin
            check_addr("o_mem.addr", log_addr, r.wb_addr);
            for (int w = 0; w < WORDS; w++) begin
                check_word("o_mem.data", log_line[w*DATA_WIDTH +: DATA_WIDTH],
                           r.wb_line[w*DATA_WIDTH +: DATA_WIDTH]);
            end
        end
    endtask

    function automatic void report_test(input int test, input int test_errors);
        if (test_errors == 0) begin
            $display("test %0d passed", test);
        end else begin
            $display("test %0d failed with %0d errors", test, test_errors);
        end
    endfunction

    initial begin
        int cur_test;
        int test_start;
        void'($urandom(47));
        n_rst     = 1'b0;
        host_re   = 1'b0;
        host_we   = 1'b0;
        host_addr = '0;
        host_data = '0;
        checks    = 0;
        errors    = 0;
        add_row(1, 1'b0, 32'h0000_0110, '0);
        add_row(2, 1'b0, 32'h0000_0120, '0);
        add_row(2, 1'b0, 32'h0000_0128, '0);
        add_row(3, 1'b1, 32'h0000_0134, 32'h1111_2222);  // write miss.
        add_row(3, 1'b0, 32'h0000_0134, '0);
        add_row(3, 1'b1, 32'h0000_0128, 32'h3333_4444);
        add_row(3, 1'b0, 32'h0000_0128, '0);
        add_row(4, 1'b0, 32'h0000_0234, '0);  // same index, other tag, so the dirty line leaves.
        add_row(4, 1'b0, 32'h0000_0134, '0);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            add_row(5, $urandom_range(1, 0) != 0, random_addr(), $urandom());
        end
        predict_table();
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        check_flag("o_busy", busy, 1'b0);
        check_flag("o_mem.req", mem_req.req, 1'b0);
        cur_test   = 1;
        test_start = 0;
        for (int i = 0; i < stim_table.size(); i++) begin
            if (stim_table[i].test != cur_test) begin
                report_test(cur_test, errors - test_start);
                cur_test   = stim_table[i].test;
                test_start = errors;
            end
            run_row(stim_table[i]);
        end
        @(posedge clk);
        host_re <= 1'b0;
        host_we <= 1'b0;
        repeat (2 * (MEM_LATENCY + 4)) @(negedge clk);  // a late write-back has landed by now.
        check_word("write-back total", word_t'(log_count), word_t'(n_evict));
        report_test(cur_test, errors - test_start);
        $display("%0d tests, %0d checks, %0d errors", cur_test, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_memory.sv
module tb_memory import cache_pkg::*, bus_pkg::*; #(
    parameter int MAX_WAIT = 6
) (
    input  logic     clk,
    input  logic     n_rst,
    input  mem_req_t i_req,
    output mem_rsp_t o_rsp,
    output int       o_wr_count,
    output addr_t    o_wr_addr,
    output line_t    o_wr_line
);

    line_t lines [addr_t];  // only lines that were written back are stored.
    logic  active;
    int    wait_cnt;

    // untouched memory follows the address rule, word by word.
    function automatic line_t read_line(input addr_t a);
        line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*DATA_WIDTH +: DATA_WIDTH] = (a + addr_t'(4 * w)) ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_rsp      <= '0;
            active     <= 1'b0;
            wait_cnt   <= 0;
            o_wr_count <= 0;
            o_wr_addr  <= '0;
            o_wr_line  <= '0;
        end else begin
            o_rsp.ack <= 1'b0;
            if (active) begin
                if (wait_cnt == 0) begin
                    o_rsp.ack <= 1'b1;
                    active    <= 1'b0;
                    if (i_req.we) begin
                        lines[i_req.addr] = i_req.data;
                        o_wr_count <= o_wr_count + 1;
                        o_wr_addr  <= i_req.addr;
                        o_wr_line  <= i_req.data;
                    end else begin
                        o_rsp.data <= read_line(i_req.addr);
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (i_req.req && !o_rsp.ack) begin  // req is still high in the ack cycle.
                active   <= 1'b1;
                wait_cnt <= $urandom_range(MAX_WAIT, 0);
            end
        end
    end

endmodule
